// ==== common/dla_csb_pkg.sv ====
`default_nettype none

package dla_csb_pkg;

  typedef struct packed {
    logic [31:0] paddr;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  // CSB addresses are word addresses taken from byte address bits 17 to 2.
  typedef struct packed {
    logic [15:0] addr;
    logic [31:0] wdat;
    logic        write;
  } csb_req_t;

  typedef struct packed {
    logic        is_write;
    logic        error;
    logic [31:0] data;
  } csb_rd_rsp_t;

  typedef struct packed {
    logic        is_write;
    logic        error;
    logic [31:0] rsvd;
  } csb_wr_rsp_t;

  // The is_write tag selects which view of the word is valid.
  typedef union packed {
    csb_rd_rsp_t rd;
    csb_wr_rsp_t wr;
  } csb_rsp_t;

  localparam logic [3:0] CSB_UNIT_GLB  = 4'd0;
  localparam logic [3:0] CSB_UNIT_SDMA = 4'd1;

  localparam logic [3:0] GLB_ID          = 4'd0;
  localparam logic [3:0] GLB_INTR_MASK   = 4'd1;
  localparam logic [3:0] GLB_INTR_STATUS = 4'd2;

  localparam logic [3:0] SDMA_SRC_ADDR = 4'd0;
  localparam logic [3:0] SDMA_DST_ADDR = 4'd1;
  localparam logic [3:0] SDMA_LEN      = 4'd2;
  localparam logic [3:0] SDMA_CTRL     = 4'd3;
  localparam logic [3:0] SDMA_STATUS   = 4'd4;
  localparam logic [3:0] SDMA_SUM      = 4'd5;

  localparam logic [31:0] DLA_HW_ID = 32'h00D1_A001;

  // Errored reads return zero data, and writes always carry a zero reserved field.
  function automatic csb_rsp_t csb_make_rsp(logic is_write, logic error, logic [31:0] rdata);
    csb_rsp_t rsp;
    if (is_write) begin
      rsp.wr.is_write = 1'b1;
      rsp.wr.error    = error;
      rsp.wr.rsvd     = '0;
    end else begin
      rsp.rd.is_write = 1'b0;
      rsp.rd.error    = error;
      rsp.rd.data     = error ? '0 : rdata;
    end
    return rsp;
  endfunction

endpackage

`default_nettype wire

// ==== common/dla_dbb_pkg.sv ====
`default_nettype none

package dla_dbb_pkg;

  localparam int DBB_ADDR_W = 32;
  localparam int DBB_DATA_W = 32;
  localparam int DBB_ID_W   = 8;

  // Shared by the AR and AW channels.
  typedef struct packed {
    logic [DBB_ID_W-1:0]   id;
    logic [3:0]            len;
    logic [DBB_ADDR_W-1:0] addr;
  } dbb_ax_t;

  typedef struct packed {
    logic [DBB_DATA_W-1:0]   data;
    logic [DBB_DATA_W/8-1:0] strb;
    logic                    last;
  } dbb_w_t;

  typedef struct packed {
    logic [DBB_ID_W-1:0] id;
  } dbb_b_t;

  typedef struct packed {
    logic [DBB_ID_W-1:0]   id;
    logic [DBB_DATA_W-1:0] data;
    logic                  last;
  } dbb_r_t;

endpackage

`default_nettype wire

// ==== rtl/apb2csb.sv ====
`timescale 1ns/1ps
`default_nettype none

module apb2csb (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire dla_csb_pkg::apb_req_t apb_req,
  output dla_csb_pkg::apb_rsp_t      apb_rsp,
  output logic                       csb_valid,
  output dla_csb_pkg::csb_req_t      csb_req,
  input  wire logic                  csb_ready,
  input  wire logic                  csb_rsp_valid,
  input  wire dla_csb_pkg::csb_rsp_t csb_rsp
);

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_REQ,
    ST_WAIT
  } state_t;

  state_t state;
  logic   access;

  // The access phase is still visible in the cycle that pready completes it.
  assign access    = apb_req.psel && apb_req.penable && !apb_rsp.pready;
  assign csb_valid = (state == ST_REQ);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= ST_IDLE;
      apb_rsp <= '0;
    end else begin
      apb_rsp.pready <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (access) state <= ST_REQ;
        end
        ST_REQ: begin
          if (csb_ready) state <= ST_WAIT;
        end
        ST_WAIT: begin
          if (csb_rsp_valid) begin
            apb_rsp.pready  <= 1'b1;
            apb_rsp.pslverr <= csb_rsp.rd.error;
            apb_rsp.prdata  <= csb_rsp.rd.is_write ? '0 : csb_rsp.rd.data;
            state           <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == ST_IDLE && access) begin
      csb_req.addr  <= apb_req.paddr[17:2];
      csb_req.wdat  <= apb_req.pwdata;
      csb_req.write <= apb_req.pwrite;
    end
  end

  // An access phase is always preceded by a setup phase.
  assert property (@(posedge clk) disable iff (!rst_n)
    apb_req.penable |-> apb_req.psel && $past(apb_req.psel));

endmodule

`default_nettype wire

// ==== dla_core/csb_master.sv ====
`timescale 1ns/1ps
`default_nettype none

module csb_master (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  csb_valid,
  input  wire dla_csb_pkg::csb_req_t csb_req,
  output logic                       csb_ready,
  output logic                       csb_rsp_valid,
  output dla_csb_pkg::csb_rsp_t      csb_rsp,
  output logic                       glb_strobe,
  output logic                       sdma_strobe,
  output dla_csb_pkg::csb_req_t      unit_req,
  input  wire logic                  glb_rsp_valid,
  input  wire logic                  sdma_rsp_valid,
  input  wire dla_csb_pkg::csb_rsp_t glb_rsp,
  input  wire dla_csb_pkg::csb_rsp_t sdma_rsp
);
  import dla_csb_pkg::*;

  logic       busy;
  logic       accept;
  logic       mapped;
  logic [3:0] unit;

  assign unit      = csb_req.addr[15:12];
  assign mapped    = (unit == CSB_UNIT_GLB) || (unit == CSB_UNIT_SDMA);
  assign accept    = csb_valid && csb_ready;
  assign csb_ready = !busy;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy          <= 1'b0;
      glb_strobe    <= 1'b0;
      sdma_strobe   <= 1'b0;
      csb_rsp_valid <= 1'b0;
    end else begin
      glb_strobe    <= accept && (unit == CSB_UNIT_GLB);
      sdma_strobe   <= accept && (unit == CSB_UNIT_SDMA);
      csb_rsp_valid <= (accept && !mapped) || glb_rsp_valid || sdma_rsp_valid;
      if (accept) begin
        busy <= 1'b1;
      end else if (csb_rsp_valid) begin
        busy <= 1'b0;
      end
    end
  end

  // Unmapped units are answered here, one cycle after acceptance.
  always_ff @(posedge clk) begin
    if (accept) unit_req <= csb_req;
    if (accept && !mapped) begin
      csb_rsp <= csb_make_rsp(csb_req.write, 1'b1, '0);
    end else if (glb_rsp_valid) begin
      csb_rsp <= glb_rsp;
    end else if (sdma_rsp_valid) begin
      csb_rsp <= sdma_rsp;
    end
  end

  assert property (@(posedge clk) disable iff (!rst_n)
    !(glb_rsp_valid && sdma_rsp_valid));

  // A unit answers only the strobe of the request that is still outstanding.
  assert property (@(posedge clk) disable iff (!rst_n)
    (glb_rsp_valid || sdma_rsp_valid) |-> busy && $past(glb_strobe || sdma_strobe));

endmodule

`default_nettype wire

// ==== dla_core/glb_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module glb_unit (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  req_strobe,
  input  wire dla_csb_pkg::csb_req_t req,
  output logic                       rsp_valid,
  output dla_csb_pkg::csb_rsp_t      rsp,
  input  wire logic                  done,
  output logic                       intr
);
  import dla_csb_pkg::*;

  logic [31:0] intr_mask;
  logic        intr_status;
  logic [31:0] rdata;
  logic        err;
  logic        wr_ok;

  always_comb begin
    rdata = '0;
    err   = 1'b0;
    case (req.addr[3:0])
      GLB_ID: begin
        rdata = DLA_HW_ID;
        err   = req.write;
      end
      GLB_INTR_MASK:   rdata = intr_mask;
      GLB_INTR_STATUS: rdata = {31'd0, intr_status};
      default:         err = 1'b1;
    endcase
  end

  assign wr_ok = req_strobe && req.write && !err;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid   <= 1'b0;
      intr_mask   <= '1;
      intr_status <= 1'b0;
      intr        <= 1'b0;
    end else begin
      rsp_valid <= req_strobe;
      if (wr_ok && req.addr[3:0] == GLB_INTR_MASK) intr_mask <= req.wdat;
      // A done pulse in the same cycle beats the write-one-to-clear.
      if (done) begin
        intr_status <= 1'b1;
      end else if (wr_ok && req.addr[3:0] == GLB_INTR_STATUS && req.wdat[0]) begin
        intr_status <= 1'b0;
      end
      intr <= intr_status && !intr_mask[0];
    end
  end

  always_ff @(posedge clk) begin
    if (req_strobe) rsp <= csb_make_rsp(req.write, err, rdata);
  end

endmodule

`default_nettype wire

// ==== dla_core/sdma_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module sdma_unit #(
  parameter int                               DMA_BURST_LEN = 4,
  parameter logic [dla_dbb_pkg::DBB_ID_W-1:0] DMA_AXI_ID    = 8'h5A
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  req_strobe,
  input  wire dla_csb_pkg::csb_req_t req,
  output logic                       rsp_valid,
  output dla_csb_pkg::csb_rsp_t      rsp,
  output logic                       ar_valid,
  output dla_dbb_pkg::dbb_ax_t       ar,
  input  wire logic                  ar_ready,
  input  wire logic                  r_valid,
  input  wire dla_dbb_pkg::dbb_r_t   r,
  output logic                       r_ready,
  output logic                       aw_valid,
  output dla_dbb_pkg::dbb_ax_t       aw,
  input  wire logic                  aw_ready,
  output logic                       w_valid,
  output dla_dbb_pkg::dbb_w_t        w,
  input  wire logic                  w_ready,
  input  wire logic                  b_valid,
  input  wire dla_dbb_pkg::dbb_b_t   b,
  output logic                       b_ready,
  output logic                       done
);
  import dla_csb_pkg::*;
  import dla_dbb_pkg::*;

  typedef enum logic [2:0] {
    S_IDLE,
    S_AR,
    S_R,
    S_W,
    S_B
  } state_t;

  state_t                state;
  logic [DBB_ADDR_W-1:0] src_addr;
  logic [DBB_ADDR_W-1:0] dst_addr;
  logic [DBB_ADDR_W-1:0] rd_addr;
  logic [7:0]            len;
  logic [7:0]            remain;
  logic [4:0]            beats_left;
  logic [4:0]            cur_beats;
  logic [DBB_DATA_W-1:0] sum;
  logic                  aw_sent;
  logic                  w_sent;
  logic                  busy;
  logic                  wr_ok;
  logic                  start;
  logic [31:0]           rdata;
  logic                  err;

  assign busy  = (state != S_IDLE);
  assign wr_ok = req_strobe && req.write && !err;
  assign start = wr_ok && req.addr[3:0] == SDMA_CTRL && req.wdat[0] && !busy;

  // The last burst of a job carries whatever is left.
  assign cur_beats = (remain > 8'(DMA_BURST_LEN)) ? 5'(DMA_BURST_LEN) : remain[4:0];

  always_comb begin
    rdata = '0;
    err   = 1'b0;
    case (req.addr[3:0])
      SDMA_SRC_ADDR: begin
        rdata = src_addr;
        err   = req.write && busy;
      end
      SDMA_DST_ADDR: begin
        rdata = dst_addr;
        err   = req.write && busy;
      end
      SDMA_LEN: begin
        rdata = {24'd0, len};
        err   = req.write && busy;
      end
      SDMA_CTRL: err = 1'b0;
      SDMA_STATUS: begin
        rdata = {31'd0, busy};
        err   = req.write;
      end
      SDMA_SUM: begin
        rdata = sum;
        err   = req.write;
      end
      default: err = 1'b1;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_valid <= 1'b0;
      src_addr  <= '0;
      dst_addr  <= '0;
      len       <= '0;
    end else begin
      rsp_valid <= req_strobe;
      if (wr_ok && req.addr[3:0] == SDMA_SRC_ADDR) src_addr <= req.wdat;
      if (wr_ok && req.addr[3:0] == SDMA_DST_ADDR) dst_addr <= req.wdat;
      if (wr_ok && req.addr[3:0] == SDMA_LEN) len <= req.wdat[7:0];
    end
  end

  always_ff @(posedge clk) begin
    if (req_strobe) rsp <= csb_make_rsp(req.write, err, rdata);
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state      <= S_IDLE;
      rd_addr    <= '0;
      remain     <= '0;
      beats_left <= '0;
      sum        <= '0;
      aw_sent    <= 1'b0;
      w_sent     <= 1'b0;
      done       <= 1'b0;
    end else begin
      done <= 1'b0;
      case (state)
        S_IDLE: begin
          if (start) begin
            sum     <= '0;
            rd_addr <= src_addr;
            remain  <= len;
            if (len == 8'd0) begin
              done <= 1'b1;
            end else begin
              state <= S_AR;
            end
          end
        end
        S_AR: begin
          if (ar_ready) begin
            beats_left <= cur_beats;
            remain     <= remain - {3'd0, cur_beats};
            rd_addr    <= rd_addr + {25'd0, cur_beats, 2'b00};
            state      <= S_R;
          end
        end
        S_R: begin
          if (r_valid) begin
            sum        <= sum + r.data;
            beats_left <= beats_left - 5'd1;
            if (beats_left == 5'd1) state <= (remain == 8'd0) ? S_W : S_AR;
          end
        end
        S_W: begin
          if (aw_valid && aw_ready) aw_sent <= 1'b1;
          if (w_valid && w_ready) w_sent <= 1'b1;
          if ((aw_sent || aw_ready) && (w_sent || w_ready)) begin
            aw_sent <= 1'b0;
            w_sent  <= 1'b0;
            state   <= S_B;
          end
        end
        S_B: begin
          if (b_valid) begin
            done  <= 1'b1;
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  assign ar_valid = (state == S_AR);
  assign ar.id    = DMA_AXI_ID;
  assign ar.len   = 4'(cur_beats - 5'd1);
  assign ar.addr  = rd_addr;
  assign r_ready  = (state == S_R);

  assign aw_valid = (state == S_W) && !aw_sent;
  assign aw.id    = DMA_AXI_ID;
  assign aw.len   = 4'd0;
  assign aw.addr  = dst_addr;
  assign w_valid  = (state == S_W) && !w_sent;
  assign w.data   = sum;
  assign w.strb   = '1;
  assign w.last   = 1'b1;
  assign b_ready  = (state == S_B);

  assert property (@(posedge clk) disable iff (!rst_n)
    ar_valid && !ar_ready |=> ar_valid && $stable(ar));

  assert property (@(posedge clk) disable iff (!rst_n)
    aw_valid && !aw_ready |=> aw_valid && $stable(aw));

  // Memory must close each burst exactly on the beat count sent in AR.
  assert property (@(posedge clk) disable iff (!rst_n)
    r_valid && r_ready |-> r.last == (beats_left == 5'd1) && r.id == DMA_AXI_ID);

  assert property (@(posedge clk) disable iff (!rst_n)
    b_valid && b_ready |-> b.id == DMA_AXI_ID);

endmodule

`default_nettype wire

// ==== dla_core/dla_core.sv ====
`timescale 1ns/1ps
`default_nettype none

module dla_core #(
  parameter int                               DMA_BURST_LEN = 4,
  parameter logic [dla_dbb_pkg::DBB_ID_W-1:0] DMA_AXI_ID    = 8'h5A
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire logic                  csb_valid,
  input  wire dla_csb_pkg::csb_req_t csb_req,
  output logic                       csb_ready,
  output logic                       csb_rsp_valid,
  output dla_csb_pkg::csb_rsp_t      csb_rsp,
  output logic                       ar_valid,
  output dla_dbb_pkg::dbb_ax_t       ar,
  input  wire logic                  ar_ready,
  input  wire logic                  r_valid,
  input  wire dla_dbb_pkg::dbb_r_t   r,
  output logic                       r_ready,
  output logic                       aw_valid,
  output dla_dbb_pkg::dbb_ax_t       aw,
  input  wire logic                  aw_ready,
  output logic                       w_valid,
  output dla_dbb_pkg::dbb_w_t        w,
  input  wire logic                  w_ready,
  input  wire logic                  b_valid,
  input  wire dla_dbb_pkg::dbb_b_t   b,
  output logic                       b_ready,
  output logic                       intr
);
  import dla_csb_pkg::*;

  logic     glb_strobe;
  logic     sdma_strobe;
  csb_req_t unit_req;
  logic     glb_rsp_valid;
  logic     sdma_rsp_valid;
  csb_rsp_t glb_rsp;
  csb_rsp_t sdma_rsp;
  logic     job_done;

  csb_master u_csb_master (
    .clk            (clk),
    .rst_n          (rst_n),
    .csb_valid      (csb_valid),
    .csb_req        (csb_req),
    .csb_ready      (csb_ready),
    .csb_rsp_valid  (csb_rsp_valid),
    .csb_rsp        (csb_rsp),
    .glb_strobe     (glb_strobe),
    .sdma_strobe    (sdma_strobe),
    .unit_req       (unit_req),
    .glb_rsp_valid  (glb_rsp_valid),
    .sdma_rsp_valid (sdma_rsp_valid),
    .glb_rsp        (glb_rsp),
    .sdma_rsp       (sdma_rsp)
  );

  glb_unit u_glb (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_strobe (glb_strobe),
    .req        (unit_req),
    .rsp_valid  (glb_rsp_valid),
    .rsp        (glb_rsp),
    .done       (job_done),
    .intr       (intr)
  );

  sdma_unit #(
    .DMA_BURST_LEN (DMA_BURST_LEN),
    .DMA_AXI_ID    (DMA_AXI_ID)
  ) u_sdma (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_strobe (sdma_strobe),
    .req        (unit_req),
    .rsp_valid  (sdma_rsp_valid),
    .rsp        (sdma_rsp),
    .ar_valid   (ar_valid),
    .ar         (ar),
    .ar_ready   (ar_ready),
    .r_valid    (r_valid),
    .r          (r),
    .r_ready    (r_ready),
    .aw_valid   (aw_valid),
    .aw         (aw),
    .aw_ready   (aw_ready),
    .w_valid    (w_valid),
    .w          (w),
    .w_ready    (w_ready),
    .b_valid    (b_valid),
    .b          (b),
    .b_ready    (b_ready),
    .done       (job_done)
  );

endmodule

`default_nettype wire

// ==== rtl/dla_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module dla_wrapper #(
  parameter int                               DMA_BURST_LEN = 4,
  parameter logic [dla_dbb_pkg::DBB_ID_W-1:0] DMA_AXI_ID    = 8'h5A
) (
  input  wire logic                  clk,
  input  wire logic                  rst_n,
  input  wire dla_csb_pkg::apb_req_t apb_req,
  output dla_csb_pkg::apb_rsp_t      apb_rsp,
  output logic                       ar_valid,
  output dla_dbb_pkg::dbb_ax_t       ar,
  input  wire logic                  ar_ready,
  input  wire logic                  r_valid,
  input  wire dla_dbb_pkg::dbb_r_t   r,
  output logic                       r_ready,
  output logic                       aw_valid,
  output dla_dbb_pkg::dbb_ax_t       aw,
  input  wire logic                  aw_ready,
  output logic                       w_valid,
  output dla_dbb_pkg::dbb_w_t        w,
  input  wire logic                  w_ready,
  input  wire logic                  b_valid,
  input  wire dla_dbb_pkg::dbb_b_t   b,
  output logic                       b_ready,
  output logic                       intr
);
  import dla_csb_pkg::*;

  logic     csb_valid;
  logic     csb_ready;
  csb_req_t csb_req;
  logic     csb_rsp_valid;
  csb_rsp_t csb_rsp;

  // The host side only sees APB, the core only sees CSB.
  apb2csb u_apb2csb (
    .clk           (clk),
    .rst_n         (rst_n),
    .apb_req       (apb_req),
    .apb_rsp       (apb_rsp),
    .csb_valid     (csb_valid),
    .csb_req       (csb_req),
    .csb_ready     (csb_ready),
    .csb_rsp_valid (csb_rsp_valid),
    .csb_rsp       (csb_rsp)
  );

  dla_core #(
    .DMA_BURST_LEN (DMA_BURST_LEN),
    .DMA_AXI_ID    (DMA_AXI_ID)
  ) u_core (
    .clk           (clk),
    .rst_n         (rst_n),
    .csb_valid     (csb_valid),
    .csb_req       (csb_req),
    .csb_ready     (csb_ready),
    .csb_rsp_valid (csb_rsp_valid),
    .csb_rsp       (csb_rsp),
    .ar_valid      (ar_valid),
    .ar            (ar),
    .ar_ready      (ar_ready),
    .r_valid       (r_valid),
    .r             (r),
    .r_ready       (r_ready),
    .aw_valid      (aw_valid),
    .aw            (aw),
    .aw_ready      (aw_ready),
    .w_valid       (w_valid),
    .w             (w),
    .w_ready       (w_ready),
    .b_valid       (b_valid),
    .b             (b),
    .b_ready       (b_ready),
    .intr          (intr)
  );

endmodule

`default_nettype wire

// ==== sim/tb_dla_wrapper.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_dla_wrapper;
  import dla_csb_pkg::*;
  import dla_dbb_pkg::*;

  localparam int           CLK_PERIOD   = 4;
  localparam int           BURST_LEN    = 4;
  localparam logic [7:0]   AXI_ID       = 8'h5A;
  localparam int unsigned  SEED         = 62828;
  localparam int           STEP_CYCLES  = 3000;
  localparam logic [31:0]  DST_OFFSET   = 32'h0000_1000;

  logic     clk;
  logic     rst_n;
  apb_req_t apb_req;
  apb_rsp_t apb_rsp;
  logic     ar_valid;
  dbb_ax_t  ar;
  logic     ar_ready;
  logic     r_valid;
  dbb_r_t   r;
  logic     r_ready;
  logic     aw_valid;
  dbb_ax_t  aw;
  logic     aw_ready;
  logic     w_valid;
  dbb_w_t   w;
  logic     w_ready;
  logic     b_valid;
  dbb_b_t   b;
  logic     b_ready;
  logic     intr;

  string       kind_q[$];
  string       name_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] val_q[$];
  int          n_steps;
  logic        steps_loaded;
  int          n_pass;
  int          n_fail;

  // Memory model state. Each accepted AR burst waits in a queue until its last beat.
  logic [31:0] rd_addr_q[$];
  int          rd_beats_q[$];
  int          beat_idx;
  dbb_ax_t     cap_aw;
  dbb_w_t      cap_w;
  logic        aw_got;
  logic        w_got;
  int          b_pend;
  int          wr_count;

  dla_wrapper #(
    .DMA_BURST_LEN (BURST_LEN),
    .DMA_AXI_ID    (AXI_ID)
  ) dut0 (
    .clk      (clk),
    .rst_n    (rst_n),
    .apb_req  (apb_req),
    .apb_rsp  (apb_rsp),
    .ar_valid (ar_valid),
    .ar       (ar),
    .ar_ready (ar_ready),
    .r_valid  (r_valid),
    .r        (r),
    .r_ready  (r_ready),
    .aw_valid (aw_valid),
    .aw       (aw),
    .aw_ready (aw_ready),
    .w_valid  (w_valid),
    .w        (w),
    .w_ready  (w_ready),
    .b_valid  (b_valid),
    .b        (b),
    .b_ready  (b_ready),
    .intr     (intr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Byte address of a register: unit in bits 17 to 14, offset in bits 5 to 2.
  function automatic logic [31:0] reg_addr(logic [3:0] unit, logic [3:0] offset);
    return {14'd0, unit, 8'd0, offset, 2'b00};
  endfunction

  function automatic apb_rsp_t apb_expect(logic [31:0] data, logic err);
    apb_rsp_t rsp;
    rsp.prdata  = data;
    rsp.pready  = 1'b1;
    rsp.pslverr = err;
    return rsp;
  endfunction

  function automatic logic [31:0] expected_sum(logic [31:0] src, int len);
    logic [31:0] sum;
    sum = '0;
    for (int i = 0; i < len; i++) begin
      sum = sum + src + 32'(4 * i);
    end
    return sum;
  endfunction

  function automatic logic random_stall();
    return ($urandom % 4) == 0;
  endfunction

  task automatic apb_transfer(input logic [31:0] addr, input logic write,
                              input logic [31:0] wdata, output apb_rsp_t rsp);
    @(posedge clk);
    #1;
    apb_req.paddr   = addr;
    apb_req.pwrite  = write;
    apb_req.pwdata  = wdata;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    do @(posedge clk); while (!apb_rsp.pready);
    rsp = apb_rsp;
    #1;
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input logic [31:0] addr, input logic [31:0] data,
                           output apb_rsp_t rsp);
    apb_transfer(addr, 1'b1, data, rsp);
  endtask

  task automatic apb_read(input logic [31:0] addr, output apb_rsp_t rsp);
    apb_transfer(addr, 1'b0, '0, rsp);
  endtask

  task automatic check_rsp(string name, apb_rsp_t exp, apb_rsp_t act);
    if (act.prdata !== exp.prdata || act.pslverr !== exp.pslverr) begin
      $display("Fail %s: expected prdata %h pslverr %b, actual prdata %h pslverr %b",
               name, exp.prdata, exp.pslverr, act.prdata, act.pslverr);
      n_fail++;
    end else begin
      $display("Ok   %s: prdata %h pslverr %b", name, act.prdata, act.pslverr);
      n_pass++;
    end
  endtask

  task automatic check_wr(string name, dbb_ax_t exp_aw, dbb_w_t exp_w,
                          dbb_ax_t act_aw, dbb_w_t act_w);
    if (act_aw !== exp_aw || act_w !== exp_w) begin
      $display("Fail %s: expected id %h len %h addr %h data %h strb %h last %b,",
               name, exp_aw.id, exp_aw.len, exp_aw.addr, exp_w.data, exp_w.strb,
               exp_w.last);
      $display("     actual id %h len %h addr %h data %h strb %h last %b",
               act_aw.id, act_aw.len, act_aw.addr, act_w.data, act_w.strb, act_w.last);
      n_fail++;
    end else begin
      $display("Ok   %s: addr %h data %h", name, act_aw.addr, act_w.data);
      n_pass++;
    end
  endtask

  task automatic check_intr(string name, logic exp, logic act);
    if (act !== exp) begin
      $display("Fail %s: expected intr %b, actual intr %b", name, exp, act);
      n_fail++;
    end else begin
      $display("Ok   %s: intr %b", name, act);
      n_pass++;
    end
  endtask

  task automatic run_job(string name, logic [31:0] src, logic [7:0] len);
    apb_rsp_t    rsp;
    dbb_ax_t     exp_aw;
    dbb_w_t      exp_w;
    logic [31:0] sum;
    int          writes_before;
    sum           = expected_sum(src, len);
    exp_aw.id     = AXI_ID;
    exp_aw.len    = 4'd0;
    exp_aw.addr   = src + DST_OFFSET;
    exp_w.data    = sum;
    exp_w.strb    = '1;
    exp_w.last    = 1'b1;
    apb_write(reg_addr(CSB_UNIT_SDMA, SDMA_SRC_ADDR), src, rsp);
    check_rsp({name, "_src"}, apb_expect('0, 1'b0), rsp);
    apb_write(reg_addr(CSB_UNIT_SDMA, SDMA_DST_ADDR), exp_aw.addr, rsp);
    check_rsp({name, "_dst"}, apb_expect('0, 1'b0), rsp);
    apb_write(reg_addr(CSB_UNIT_SDMA, SDMA_LEN), {24'd0, len}, rsp);
    check_rsp({name, "_len"}, apb_expect('0, 1'b0), rsp);
    writes_before = wr_count;
    apb_write(reg_addr(CSB_UNIT_SDMA, SDMA_CTRL), 32'd1, rsp);
    check_rsp({name, "_start"}, apb_expect('0, 1'b0), rsp);
    // Long jobs are still running when the next register write arrives.
    if (len >= 8) begin
      apb_write(reg_addr(CSB_UNIT_SDMA, SDMA_SRC_ADDR), ~src, rsp);
      check_rsp({name, "_busy"}, apb_expect('0, 1'b1), rsp);
    end
    do apb_read(reg_addr(CSB_UNIT_SDMA, SDMA_STATUS), rsp); while (rsp.prdata[0]);
    if (wr_count != writes_before + 1) begin
      $display("%s: expected one DBB write for the job, saw %0d", name,
               wr_count - writes_before);
      n_fail++;
    end else begin
      check_wr({name, "_write"}, exp_aw, exp_w, cap_aw, cap_w);
    end
    apb_read(reg_addr(CSB_UNIT_SDMA, SDMA_SUM), rsp);
    check_rsp({name, "_sum"}, apb_expect(sum, 1'b0), rsp);
  endtask

  initial begin : dbb_memory
    logic r_fire;
    logic b_fire;
    void'($urandom(SEED));
    ar_ready = 1'b0;
    r_valid  = 1'b0;
    r        = '0;
    aw_ready = 1'b0;
    w_ready  = 1'b0;
    b_valid  = 1'b0;
    b        = '0;
    beat_idx = 0;
    aw_got   = 1'b0;
    w_got    = 1'b0;
    b_pend   = 0;
    wr_count = 0;
    forever begin
      @(posedge clk);
      r_fire = r_valid && r_ready;
      b_fire = b_valid && b_ready;
      if (ar_valid && ar_ready) begin
        if (ar.id !== AXI_ID) begin
          $display("Read burst at %h carried ID %h instead of %h", ar.addr, ar.id, AXI_ID);
          n_fail++;
        end
        rd_addr_q.push_back(ar.addr);
        rd_beats_q.push_back(int'(ar.len) + 1);
      end
      if (r_fire) begin
        beat_idx++;
        if (beat_idx == rd_beats_q[0]) begin
          void'(rd_addr_q.pop_front());
          void'(rd_beats_q.pop_front());
          beat_idx = 0;
        end
      end
      if (aw_valid && aw_ready) begin
        cap_aw = aw;
        aw_got = 1'b1;
      end
      if (w_valid && w_ready) begin
        cap_w = w;
        w_got = 1'b1;
      end
      if (aw_got && w_got) begin
        aw_got = 1'b0;
        w_got  = 1'b0;
        b_pend++;
        wr_count++;
      end
      if (b_fire) b_pend--;
      #1;
      ar_ready = !random_stall();
      aw_ready = !random_stall();
      w_ready  = !random_stall();
      // A raised valid holds its beat until the DUT takes it.
      if (r_fire || !r_valid) begin
        if (rd_addr_q.size() > 0 && !random_stall()) begin
          r_valid = 1'b1;
          r.id    = AXI_ID;
          r.data  = rd_addr_q[0] + 32'(4 * beat_idx);
          r.last  = (beat_idx == rd_beats_q[0] - 1);
        end else begin
          r_valid = 1'b0;
        end
      end
      if (b_fire || !b_valid) begin
        b_valid = (b_pend > 0) && !random_stall();
        b.id    = AXI_ID;
      end
    end
  end

  initial begin : watchdog
    int limit;
    wait (steps_loaded);
    limit = (n_steps > 0 ? n_steps : 1) * STEP_CYCLES;
    repeat (limit) @(posedge clk);
    $display("Timeout: the tests did not finish within %0d cycles", limit);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    int          fd;
    int          cnt;
    string       line;
    string       kind;
    string       name;
    logic [31:0] addr;
    logic [31:0] val;
    apb_rsp_t    rsp;
    apb_req      = '0;
    rst_n        = 1'b0;
    n_steps      = 0;
    n_pass       = 0;
    n_fail       = 0;
    steps_loaded = 1'b0;
    fd = $fopen("sim/dla_patterns.txt", "r");
    if (fd == 0) begin
      $display("Could not open the pattern file sim/dla_patterns.txt");
      n_fail++;
    end else begin
      while (!$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#") begin
          cnt = $sscanf(line, "%s %s %h %h", kind, name, addr, val);
          if (cnt == 4) begin
            kind_q.push_back(kind);
            name_q.push_back(name);
            addr_q.push_back(addr);
            val_q.push_back(val);
          end else if (cnt > 0) begin
            $display("Malformed pattern line: %s", line);
            n_fail++;
          end
        end
      end
      $fclose(fd);
    end
    n_steps      = kind_q.size();
    steps_loaded = 1'b1;
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    for (int i = 0; i < n_steps; i++) begin
      case (kind_q[i])
        "write": begin
          apb_write(addr_q[i], val_q[i], rsp);
          check_rsp(name_q[i], apb_expect('0, 1'b0), rsp);
        end
        "read": begin
          apb_read(addr_q[i], rsp);
          check_rsp(name_q[i], apb_expect(val_q[i], 1'b0), rsp);
        end
        "error": begin
          if (val_q[i] == '0) begin
            apb_read(addr_q[i], rsp);
          end else begin
            apb_write(addr_q[i], val_q[i], rsp);
          end
          check_rsp(name_q[i], apb_expect('0, 1'b1), rsp);
        end
        "job": run_job(name_q[i], addr_q[i], val_q[i][7:0]);
        "intr": begin
          @(posedge clk);
          check_intr(name_q[i], val_q[i][0], intr);
        end
        default: begin
          $display("%s: unknown pattern kind %s", name_q[i], kind_q[i]);
          n_fail++;
        end
      endcase
    end
    $display("Tests: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sim/dla_patterns.txt ====
# kind name address value, numbers in hex. write/read: data written or expected read data.
# error: value 0 reads, else writes it. job: address is SRC, value is LEN, DST is SRC+0x1000.
read  rst_id        00000000 00D1A001
read  rst_mask      00000004 FFFFFFFF
read  rst_intr_st   00000008 00000000
read  rst_sdma_st   00004010 00000000
read  rst_sum       00004014 00000000
intr  rst_intr      00000000 00000000
write wr_src        00004000 12345678
read  rd_src        00004000 12345678
write wr_dst        00004004 CAFE0010
read  rd_dst        00004004 CAFE0010
write wr_len        00004008 00000A37
read  rd_len        00004008 00000037
write wr_mask       00000004 A5A5A5A4
read  rd_mask       00000004 A5A5A5A4
write mask_all      00000004 FFFFFFFF
error err_unmapped  00008000 00000000
error err_unit15_wr 0003C000 00000001
error err_glb_id_wr 00000000 00000001
error err_glb_off   0000000C 00000000
error err_sdma_off  00004018 00000000
error err_sum_wr    00004014 00000001
job   job_len7      00001000 00000007
intr  intr_masked   00000000 00000000
read  intr_st_set   00000008 00000001
write unmask        00000004 00000000
intr  intr_raised   00000000 00000001
write intr_clear    00000008 00000001
intr  intr_low      00000000 00000000
read  intr_st_clr   00000008 00000000
job   job_len13     00020000 0000000D
job   job_len30     FFFFFFC0 0000001E
job   job_len1      00300000 00000001
job   job_len13_rep 00020000 0000000D

// ==== vlog.f ====
common/dla_csb_pkg.sv
common/dla_dbb_pkg.sv
rtl/apb2csb.sv
dla_core/csb_master.sv
dla_core/glb_unit.sv
dla_core/sdma_unit.sv
dla_core/dla_core.sv
rtl/dla_wrapper.sv
sim/tb_dla_wrapper.sv

// ==== Bender.yml ====
package:
  name: dla_subsystem

sources:
  - common/dla_csb_pkg.sv
  - common/dla_dbb_pkg.sv
  - rtl/apb2csb.sv
  - dla_core/csb_master.sv
  - dla_core/glb_unit.sv
  - dla_core/sdma_unit.sv
  - dla_core/dla_core.sv
  - rtl/dla_wrapper.sv
  - target: test
    files:
      - sim/tb_dla_wrapper.sv
